/* bist_fifo_top.f */
+incdir+hw
hw/bist_fifo_pkg.sv
hw/stream_if.sv
hw/wb_regs.sv
hw/bist_gen.sv
hw/bist_check.sv
hw/fifo_write_router.sv
hw/fifo_bank.sv
hw/fifo_read_merge.sv
hw/bist_fifo_top.sv
tests/bist_fifo_tb.sv

/* tests/bist_fifo_tb.sv */
// BIST FIFO testbench
// Directed tests for user traffic, BIST patterns, fault injection and continuous runs
`timescale 1ns/1ns
`include "bist_fifo_defs.svh"

module bist_fifo_tb
  import bist_fifo_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  // Cycle budgets per test
  localparam int T_RESET      = 300;
  localparam int T_FILL       = 1500;
  localparam int T_CONCURRENT = 2000;
  localparam int T_PATTERNS   = 3000;
  localparam int T_FAULT      = 2000;
  localparam int T_CONTINUOUS = 2500;
  localparam int TIMEOUT_CYCLES = 8 + T_RESET + T_FILL + T_CONCURRENT + T_PATTERNS
                                  + T_FAULT + T_CONTINUOUS;

  logic       bus_clk;
  logic       reset;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [2:0] wb_adr;
  word_t      wb_dat_i;
  word_t      wb_dat_o;
  logic       wb_ack;
  word_t      in_data;
  logic       in_last;
  logic       in_valid;
  logic       in_ready;
  word_t      out_data;
  logic       out_last;
  logic       out_valid;
  logic       out_ready;
  word_t      force_bit_err;

  // Words expected at the user output, in order
  word_t exp_data [$];
  logic  exp_last [$];

  logic [31:0] lcg_state = 32'hff1e;
  int          tests_run = 0;
  int          check_count = 0;
  int          error_count = 0;

  bist_fifo_top dut (.*);

  initial
  begin
    bus_clk = 1'b0;
    forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
  end

  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, run stopped", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // --------------------------------------------------
  // Checks
  task automatic compare_word(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_err(input string name, input bist_err_t got, input bist_err_t exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_count(input string name, input perf_cnt_t got, input perf_cnt_t exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    check_count++;
    error_count++;
    $display("Error: %s", msg);
  endtask

  task automatic report_test(input string name, input int errors_at_start);
    tests_run++;
    if (error_count == errors_at_start)
      $display("Test %s: ok", name);
    else
      $display("Test %s: %0d errors", name, error_count - errors_at_start);
  endtask

  // --------------------------------------------------
  // Wishbone master
  task automatic wb_access(input logic we, input logic [2:0] adr, input word_t wdata,
                           output word_t rdata);
    int waited;
    @(posedge bus_clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_i <= wdata;
    waited = 0;
    @(negedge bus_clk);
    while (!wb_ack && waited < 16)
    begin
      @(negedge bus_clk);
      waited++;
    end
    if (!wb_ack)
      note_failure("Wishbone access got no ack");
    rdata = wb_dat_o;
    @(posedge bus_clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [2:0] adr, input word_t data);
    word_t unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [2:0] adr, output word_t data);
    wb_access(1'b0, adr, '0, data);
  endtask

  // --------------------------------------------------
  // User stream
  task automatic send_packet(input int len);
    word_t w;
    int    waited;
    @(posedge bus_clk);
    for (int i = 0; i < len; i++)
    begin
      w = next_rand();
      exp_data.push_back(w);
      exp_last.push_back(i == len - 1);
      in_valid <= 1'b1;
      in_data  <= w;
      in_last  <= (i == len - 1);
      waited = 0;
      @(negedge bus_clk);
      while (!in_ready && waited < 400)
      begin
        @(negedge bus_clk);
        waited++;
      end
      if (!in_ready)
        note_failure("in_ready stayed low while sending a packet");
      // Word moves on this edge
      @(posedge bus_clk);
    end
    in_valid <= 1'b0;
    in_last  <= 1'b0;
  endtask

  task automatic receive_words(input int count, input bit gaps);
    word_t r;
    int    got;
    int    idle;
    got = 0;
    idle = 0;
    while (got < count && idle < 200)
    begin
      @(posedge bus_clk);
      r = next_rand();
      out_ready <= gaps ? (r[17:16] != 2'b00) : 1'b1;
      @(negedge bus_clk);
      if (out_valid && out_ready)
      begin
        if (exp_data.size() == 0)
          note_failure("output word arrived with nothing expected");
        else
        begin
          compare_word("out_data", out_data, exp_data.pop_front());
          compare_flag("out_last", out_last, exp_last.pop_front());
        end
        got++;
        idle = 0;
      end
      else
        idle++;
    end
    @(posedge bus_clk);
    out_ready <= 1'b0;
    if (got < count)
      note_failure("output stopped before all words arrived");
  endtask

  // --------------------------------------------------
  // BIST control
  task automatic bist_configure(input logic ramp, input pkt_len_t len, input pkt_cnt_t cnt,
                                input word_t seed);
    wb_write(`REG_PKT, {7'd0, ramp, len, cnt});
    wb_write(`REG_SEED, seed);
  endtask

  task automatic wait_done(input int max_cycles, output word_t status);
    int polls;
    polls = 0;
    wb_read(`REG_STATUS, status);
    while (!status[1] && polls < max_cycles / 3)
    begin
      wb_read(`REG_STATUS, status);
      polls++;
    end
    if (!status[1])
      note_failure("BIST run did not reach done");
    compare_flag("running", status[0], 1'b0);
  endtask

  task automatic bist_run(input logic ramp, input pkt_len_t len, input pkt_cnt_t cnt,
                          input word_t seed, output bist_err_t err,
                          output perf_cnt_t xfer, output perf_cnt_t cyc);
    word_t status;
    word_t value;
    bist_configure(ramp, len, cnt, seed);
    wb_write(`REG_CTRL, 32'h1);
    wait_done(int'(len) * int'(cnt) * 4 + 200, status);
    err = status[3:2];
    wb_read(`REG_XFER, value);
    xfer = value;
    wb_read(`REG_CYC, value);
    cyc = value;
    wb_write(`REG_CTRL, 32'h0);
  endtask

  // --------------------------------------------------
  // Tests
  task automatic test_reset_defaults();
    int    errs;
    word_t value;
    errs = error_count;
    @(negedge bus_clk);
    compare_flag("out_valid", out_valid, 1'b0);
    compare_flag("in_ready", in_ready, 1'b1);
    compare_flag("wb_ack", wb_ack, 1'b0);
    wb_read(`REG_STATUS, value);
    compare_word("status", value, 32'h0);
    wb_write(`REG_SEED, 32'hc3a5_96e1);
    wb_read(`REG_SEED, value);
    compare_word("seed", value, 32'hc3a5_96e1);
    wb_write(`REG_PKT, 32'h0123_4567);
    wb_read(`REG_PKT, value);
    compare_word("pkt", value, 32'h0123_4567);
    report_test("reset_defaults", errs);
  endtask

  task automatic test_fill_drain();
    int errs;
    errs = error_count;
    send_packet(40);
    receive_words(40, 1'b0);
    // Full FIFO holds off the source
    send_packet(64);
    @(negedge bus_clk);
    compare_flag("in_ready", in_ready, 1'b0);
    receive_words(64, 1'b0);
    if (exp_data.size() != 0)
      note_failure("words left over after the fill and drain");
    report_test("fill_drain", errs);
  endtask

  task automatic test_concurrent_traffic();
    int errs;
    errs = error_count;
    fork
      begin
        send_packet(50);
        send_packet(70);
      end
      receive_words(120, 1'b1);
    join
    if (exp_data.size() != 0)
      note_failure("words left over after concurrent traffic");
    report_test("concurrent_traffic", errs);
  endtask

  task automatic test_bist_patterns();
    int        errs;
    bist_err_t err;
    perf_cnt_t xfer;
    perf_cnt_t cyc;
    errs = error_count;
    bist_run(1'b0, 8'd8, 16'd10, 32'h5a5a_0f0f, err, xfer, cyc);
    compare_err("err", err, 2'b00);
    compare_count("xfer_cnt", xfer, 32'd80);
    if (cyc < xfer)
      note_failure("cycle count is below the word count in constant mode");
    // Ramp wraps through zero
    bist_run(1'b1, 8'd12, 16'd20, 32'hffff_fff0, err, xfer, cyc);
    compare_err("err", err, 2'b00);
    compare_count("xfer_cnt", xfer, 32'd240);
    if (cyc < xfer)
      note_failure("cycle count is below the word count in ramp mode");
    report_test("bist_patterns", errs);
  endtask

  task automatic test_fault_injection();
    int        errs;
    bist_err_t err;
    perf_cnt_t xfer;
    perf_cnt_t cyc;
    errs = error_count;
    @(posedge bus_clk);
    force_bit_err <= 32'h0000_0100;
    bist_run(1'b1, 8'd6, 16'd5, 32'h0000_1000, err, xfer, cyc);
    compare_err("err", err, 2'b01);
    @(posedge bus_clk);
    force_bit_err <= '0;
    bist_run(1'b1, 8'd6, 16'd5, 32'h0000_1000, err, xfer, cyc);
    compare_err("err", err, 2'b00);
    compare_count("xfer_cnt", xfer, 32'd30);
    report_test("fault_injection", errs);
  endtask

  task automatic test_continuous_run();
    int        errs;
    word_t     status;
    word_t     value;
    perf_cnt_t xfer;
    errs = error_count;
    bist_configure(1'b1, 8'd8, 16'd4, 32'h0000_0200);
    wb_write(`REG_CTRL, 32'h3);
    repeat (300) @(posedge bus_clk);
    // Keep continuous set and drop start
    wb_write(`REG_CTRL, 32'h2);
    wait_done(1000, status);
    compare_err("err", status[3:2], 2'b00);
    wb_read(`REG_XFER, value);
    xfer = value;
    compare_count("xfer_cnt mod length", xfer % 8, 32'd0);
    if (xfer <= 32)
      note_failure("continuous run moved no more than one count of packets");
    wb_write(`REG_CTRL, 32'h0);
    report_test("continuous_run", errs);
  endtask

  // --------------------------------------------------
  // Main sequence
  initial
  begin
    reset         = 1'b1;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_i      = '0;
    in_data       = '0;
    in_last       = 1'b0;
    in_valid      = 1'b0;
    out_ready     = 1'b0;
    force_bit_err = '0;
    repeat (8) @(posedge bus_clk);
    reset <= 1'b0;

    test_reset_defaults();
    test_fill_drain();
    test_concurrent_traffic();
    test_bist_patterns();
    test_fault_injection();
    test_continuous_run();

    $display("Tests run %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
    if (error_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* hw/bist_fifo_top.sv */
// BIST FIFO top level
// Register slave, BIST generator and checker around a banked packet FIFO
`timescale 1ns/1ns
`include "bist_fifo_defs.svh"

module bist_fifo_top
  import bist_fifo_pkg::*;
(
  input  logic       bus_clk,
  input  logic       reset,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  logic [2:0] wb_adr,
  input  word_t      wb_dat_i,
  output word_t      wb_dat_o,
  output logic       wb_ack,
  input  word_t      in_data,
  input  logic       in_last,
  input  logic       in_valid,
  output logic       in_ready,
  output word_t      out_data,
  output logic       out_last,
  output logic       out_valid,
  input  logic       out_ready,
  input  word_t      force_bit_err
);

  logic      start;
  logic      continuous;
  logic      ramp;
  word_t     seed;
  pkt_len_t  pkt_len;
  pkt_cnt_t  pkt_cnt;
  logic      running;
  logic      done;
  bist_err_t err;
  perf_cnt_t xfer_cnt;
  perf_cnt_t cyc_cnt;

  stream_if bist_stream ();
  stream_if chk_stream ();
  stream_if bank_in [`BANK_COUNT] ();
  stream_if bank_out [`BANK_COUNT] ();

  // --------------------------------------------------
  // Control and BIST
  wb_regs u_regs (
    .bus_clk, .reset,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
    .start, .continuous, .ramp, .seed, .pkt_len, .pkt_cnt,
    .running, .done, .err, .xfer_cnt, .cyc_cnt
  );

  bist_gen u_gen (
    .bus_clk, .reset,
    .start, .continuous, .ramp, .seed, .pkt_len, .pkt_cnt,
    .out (bist_stream)
  );

  bist_check u_check (
    .bus_clk, .reset,
    .start, .continuous, .ramp, .seed, .pkt_len, .pkt_cnt,
    .in (chk_stream),
    .running, .done, .err, .xfer_cnt, .cyc_cnt
  );

  // --------------------------------------------------
  // Banked FIFO
  fifo_write_router u_router (
    .bus_clk, .reset, .running,
    .in_data, .in_last, .in_valid, .in_ready,
    .bist (bist_stream),
    .bank (bank_in)
  );

  for (genvar i = 0; i < `BANK_COUNT; i++)
  begin : g_bank
    fifo_bank u_bank (
      .bus_clk, .reset,
      .wr (bank_in[i]),
      .rd (bank_out[i])
    );
  end

  fifo_read_merge u_merge (
    .bus_clk, .reset, .running, .force_bit_err,
    .bank (bank_out),
    .out_data, .out_last, .out_valid, .out_ready,
    .chk (chk_stream)
  );

endmodule

/* hw/fifo_read_merge.sv */
// FIFO read merger
// Drains the banks in write order, injects bit faults
// and steers words to the checker or the user output
`timescale 1ns/1ns
`include "bist_fifo_defs.svh"

module fifo_read_merge
  import bist_fifo_pkg::*;
(
  input  logic     bus_clk,
  input  logic     reset,
  input  logic     running,
  input  word_t    force_bit_err,
  stream_if.sink   bank [`BANK_COUNT],
  output word_t    out_data,
  output logic     out_last,
  output logic     out_valid,
  input  logic     out_ready,
  stream_if.source chk
);

  localparam int PTR_W = $clog2(`BANK_COUNT);

  logic [PTR_W-1:0]       rd_ptr;
  word_t                  bank_data [`BANK_COUNT];
  logic [`BANK_COUNT-1:0] bank_last;
  logic [`BANK_COUNT-1:0] bank_valid;
  word_t                  sel_data;
  logic                   sel_last;
  logic                   sel_valid;
  logic                   sel_ready;

  for (genvar i = 0; i < `BANK_COUNT; i++)
  begin : g_bank
    assign bank_data[i]  = bank[i].data;
    assign bank_last[i]  = bank[i].last;
    assign bank_valid[i] = bank[i].valid;
    assign bank[i].ready = sel_ready && (rd_ptr == PTR_W'(i));
  end

  // Forced bits model a stuck memory cell
  assign sel_data  = bank_data[rd_ptr] ^ force_bit_err;
  assign sel_last  = bank_last[rd_ptr];
  assign sel_valid = bank_valid[rd_ptr];
  assign sel_ready = running ? chk.ready : out_ready;

  assign chk.data  = sel_data;
  assign chk.last  = sel_last;
  assign chk.valid = running && sel_valid;
  assign out_data  = sel_data;
  assign out_last  = sel_last;
  assign out_valid = !running && sel_valid;

  always_ff @(posedge bus_clk)
  begin
    if (reset)
      rd_ptr <= '0;
    else if (sel_valid && sel_ready)
      rd_ptr <= rd_ptr + 1'b1;
  end

endmodule

/* hw/fifo_bank.sv */
// FIFO bank
// Circular buffer of data and last with a registered output stage
`timescale 1ns/1ns
`include "bist_fifo_defs.svh"

module fifo_bank
  import bist_fifo_pkg::*;
(
  input  logic     bus_clk,
  input  logic     reset,
  stream_if.sink   wr,
  stream_if.source rd
);

  localparam int ADDR_W = $clog2(`BANK_DEPTH);

  word_t             mem_data [`BANK_DEPTH];
  logic              mem_last [`BANK_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  // Words held in the bank, output stage included
  logic [ADDR_W:0]   count;
  logic [ADDR_W:0]   mem_words;
  logic              wr_fire;
  logic              rd_fire;
  logic              load;
  logic              out_valid;
  word_t             out_data;
  logic              out_last;

  assign wr_fire   = wr.valid && wr.ready;
  assign rd_fire   = rd.valid && rd.ready;
  assign mem_words = count - out_valid;
  assign load      = (mem_words != '0) && (!out_valid || rd.ready);
  assign wr.ready  = (count < `BANK_DEPTH);
  assign rd.valid  = out_valid;
  assign rd.data   = out_data;
  assign rd.last   = out_last;

  always_ff @(posedge bus_clk)
  begin
    if (reset)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end
    else
    begin
      if (wr_fire)
        wr_ptr <= wr_ptr + 1'b1;
      if (load)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + wr_fire - rd_fire;
      if (load)
        out_valid <= 1'b1;
      else if (rd_fire)
        out_valid <= 1'b0;
    end
  end

  // --------------------------------------------------
  // Storage and output stage
  always_ff @(posedge bus_clk)
  begin
    if (wr_fire)
    begin
      mem_data[wr_ptr] <= wr.data;
      mem_last[wr_ptr] <= wr.last;
    end
    if (load)
    begin
      out_data <= mem_data[rd_ptr];
      out_last <= mem_last[rd_ptr];
    end
  end

  // A write must never land on a slot that still holds an unread word
  a_no_overflow: assert property (@(posedge bus_clk) disable iff (reset)
    wr_fire |-> !(wr_ptr == rd_ptr && mem_words != '0));

  a_no_underflow: assert property (@(posedge bus_clk) disable iff (reset)
    rd_fire |-> count != '0);

endmodule

/* hw/fifo_write_router.sv */
// FIFO write router
// Picks the user or BIST stream and deals words to the banks in turn
`timescale 1ns/1ns
`include "bist_fifo_defs.svh"

module fifo_write_router
  import bist_fifo_pkg::*;
(
  input  logic     bus_clk,
  input  logic     reset,
  input  logic     running,
  input  word_t    in_data,
  input  logic     in_last,
  input  logic     in_valid,
  output logic     in_ready,
  stream_if.sink   bist,
  stream_if.source bank [`BANK_COUNT]
);

  localparam int PTR_W = $clog2(`BANK_COUNT);

  logic [PTR_W-1:0]       wr_ptr;
  logic [`BANK_COUNT-1:0] bank_ready;
  word_t                  sel_data;
  logic                   sel_last;
  logic                   sel_valid;
  logic                   sel_ready;

  // BIST owns the FIFO while a run is active
  assign sel_data   = running ? bist.data : in_data;
  assign sel_last   = running ? bist.last : in_last;
  assign sel_valid  = running ? bist.valid : in_valid;
  assign sel_ready  = bank_ready[wr_ptr];
  assign in_ready   = !running && sel_ready;
  assign bist.ready = running && sel_ready;

  for (genvar i = 0; i < `BANK_COUNT; i++)
  begin : g_bank
    assign bank[i].data  = sel_data;
    assign bank[i].last  = sel_last;
    assign bank[i].valid = sel_valid && (wr_ptr == PTR_W'(i));
    assign bank_ready[i] = bank[i].ready;
  end

  always_ff @(posedge bus_clk)
  begin
    if (reset)
      wr_ptr <= '0;
    else if (sel_valid && sel_ready)
      wr_ptr <= wr_ptr + 1'b1;
  end

endmodule

/* hw/bist_check.sv */
// BIST checker
// Rebuilds the generator sequence, flags data and framing errors
// and counts words and cycles for throughput
`timescale 1ns/1ns

module bist_check
  import bist_fifo_pkg::*;
(
  input  logic      bus_clk,
  input  logic      reset,
  input  logic      start,
  input  logic      continuous,
  input  logic      ramp,
  input  word_t     seed,
  input  pkt_len_t  pkt_len,
  input  pkt_cnt_t  pkt_cnt,
  stream_if.sink    in,
  output logic      running,
  output logic      done,
  output bist_err_t err,
  output perf_cnt_t xfer_cnt,
  output perf_cnt_t cyc_cnt
);

  // Quiet cycles at a packet boundary that close a continuous stop
  localparam int DRAIN_IDLE = 8;

  bist_state_t state;
  logic        start_q;
  logic        run_edge;
  logic        fire;
  logic        exp_last;
  logic        final_pkt;
  logic [3:0]  idle_cnt;
  pkt_len_t    word_idx;
  pkt_cnt_t    pkt_num;
  word_t       exp_word;

  assign in.ready  = 1'b1;
  assign running   = (state == RUN) || (state == DRAIN);
  assign done      = (state == DONE);
  assign run_edge  = start && !start_q;
  assign fire      = running && in.valid;
  assign exp_last  = (word_idx == pkt_len - 1'b1);
  assign final_pkt = (pkt_num == pkt_cnt - 1'b1);

  always_ff @(posedge bus_clk)
  begin
    if (reset)
    begin
      state    <= IDLE;
      start_q  <= 1'b0;
      err      <= ERR_NONE;
      word_idx <= '0;
      pkt_num  <= '0;
      idle_cnt <= '0;
      xfer_cnt <= '0;
      cyc_cnt  <= '0;
    end
    else
    begin
      start_q <= start;
      case (state)
        RUN, DRAIN:
        begin
          cyc_cnt <= cyc_cnt + 1'b1;
          if (fire)
          begin
            xfer_cnt <= xfer_cnt + 1'b1;
            idle_cnt <= '0;
            // First error sticks
            if (err == ERR_NONE && in.data != exp_word)
              err <= ERR_DATA;
            else if (err == ERR_NONE && in.last != exp_last)
              err <= ERR_LAST;
            if (exp_last)
            begin
              word_idx <= '0;
              pkt_num  <= pkt_num + 1'b1;
              if (state == RUN && !continuous && final_pkt)
                state <= DONE;
            end
            else
              word_idx <= word_idx + 1'b1;
          end
          else if (state == DRAIN && word_idx == '0)
          begin
            idle_cnt <= idle_cnt + 1'b1;
            if (idle_cnt == 4'(DRAIN_IDLE - 1))
              state <= DONE;
          end
          if (state == RUN && continuous && !start)
            state <= DRAIN;
        end
        default:
        begin
          if (run_edge)
          begin
            state    <= RUN;
            err      <= ERR_NONE;
            word_idx <= '0;
            pkt_num  <= '0;
            idle_cnt <= '0;
            xfer_cnt <= '0;
            cyc_cnt  <= '0;
          end
          else if (state == DONE && !start && start_q)
          begin
            state <= IDLE;
            err   <= ERR_NONE;
          end
        end
      endcase
    end
  end

  // Expected word follows the generator rules
  always_ff @(posedge bus_clk)
  begin
    if (run_edge && !running)
      exp_word <= seed;
    else if (fire && ramp)
      exp_word <= exp_word + 1'b1;
  end

endmodule

/* hw/bist_gen.sv */
// BIST packet generator
// Emits fixed-length packets of constant or ramping words from the seed
`timescale 1ns/1ns

module bist_gen
  import bist_fifo_pkg::*;
(
  input  logic     bus_clk,
  input  logic     reset,
  input  logic     start,
  input  logic     continuous,
  input  logic     ramp,
  input  word_t    seed,
  input  pkt_len_t pkt_len,
  input  pkt_cnt_t pkt_cnt,
  stream_if.source out
);

  bist_state_t state;
  logic        start_q;
  logic        run_edge;
  logic        fire;
  logic        final_pkt;
  pkt_len_t    word_idx;
  pkt_cnt_t    pkt_num;
  word_t       word_q;

  assign run_edge  = start && !start_q;
  assign fire      = out.valid && out.ready;
  assign final_pkt = (pkt_num == pkt_cnt - 1'b1);

  assign out.valid = (state == RUN) || (state == DRAIN);
  assign out.data  = word_q;
  assign out.last  = (word_idx == pkt_len - 1'b1);

  always_ff @(posedge bus_clk)
  begin
    if (reset)
    begin
      state    <= IDLE;
      start_q  <= 1'b0;
      word_idx <= '0;
      pkt_num  <= '0;
    end
    else
    begin
      start_q <= start;
      case (state)
        RUN, DRAIN:
        begin
          if (fire && out.last)
          begin
            word_idx <= '0;
            pkt_num  <= pkt_num + 1'b1;
            if (state == DRAIN || (continuous ? !start : final_pkt))
              state <= DONE;
          end
          else
          begin
            if (fire)
              word_idx <= word_idx + 1'b1;
            // Stop request lets the current packet finish
            if (state == RUN && continuous && !start)
              state <= DRAIN;
          end
        end
        default:
        begin
          if (run_edge)
          begin
            state    <= RUN;
            word_idx <= '0;
            pkt_num  <= '0;
          end
          else if (state == DONE && !start)
            state <= IDLE;
        end
      endcase
    end
  end

  // Ramp carries on across packet boundaries
  always_ff @(posedge bus_clk)
  begin
    if (run_edge && !out.valid)
      word_q <= seed;
    else if (fire && ramp)
      word_q <= word_q + 1'b1;
  end

  a_out_stable: assert property (@(posedge bus_clk) disable iff (reset)
    out.valid && !out.ready |=> out.valid && $stable(out.data) && $stable(out.last));

endmodule

/* hw/wb_regs.sv */
// Wishbone classic register slave
// Holds BIST control, packet and seed fields and returns status and counters
`timescale 1ns/1ns
`include "bist_fifo_defs.svh"

module wb_regs
  import bist_fifo_pkg::*;
(
  input  logic       bus_clk,
  input  logic       reset,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  logic [2:0] wb_adr,
  input  word_t      wb_dat_i,
  output word_t      wb_dat_o,
  output logic       wb_ack,
  output logic       start,
  output logic       continuous,
  output logic       ramp,
  output word_t      seed,
  output pkt_len_t   pkt_len,
  output pkt_cnt_t   pkt_cnt,
  input  logic       running,
  input  logic       done,
  input  bist_err_t  err,
  input  perf_cnt_t  xfer_cnt,
  input  perf_cnt_t  cyc_cnt
);

  logic  req;
  word_t rd_word;

  // Request not yet acknowledged
  assign req = wb_cyc && wb_stb && !wb_ack;

  always_comb
  begin
    case (wb_adr)
      `REG_CTRL:   rd_word = {30'd0, continuous, start};
      `REG_PKT:    rd_word = {7'd0, ramp, pkt_len, pkt_cnt};
      `REG_SEED:   rd_word = seed;
      `REG_STATUS: rd_word = {28'd0, err, done, running};
      `REG_XFER:   rd_word = xfer_cnt;
      `REG_CYC:    rd_word = cyc_cnt;
      default:     rd_word = '0;
    endcase
  end

  // --------------------------------------------------
  // Writable fields and the one-cycle ack
  always_ff @(posedge bus_clk)
  begin
    if (reset)
    begin
      wb_ack     <= 1'b0;
      start      <= 1'b0;
      continuous <= 1'b0;
      ramp       <= 1'b0;
      pkt_len    <= '0;
      pkt_cnt    <= '0;
      seed       <= '0;
    end
    else
    begin
      wb_ack <= req;
      if (req && wb_we)
      begin
        case (wb_adr)
          `REG_CTRL: {continuous, start} <= wb_dat_i[1:0];
          `REG_PKT:  {ramp, pkt_len, pkt_cnt} <= wb_dat_i[24:0];
          `REG_SEED: seed <= wb_dat_i;
          default:   ;
        endcase
      end
    end
  end

  // Read data lines up with ack
  always_ff @(posedge bus_clk)
  begin
    if (req)
      wb_dat_o <= rd_word;
  end

  a_ack_single: assert property (@(posedge bus_clk) disable iff (reset)
    wb_ack |=> !wb_ack);

endmodule

/* hw/stream_if.sv */
// Stream interface
// Valid/ready handshake carrying one word and a last flag per transfer
`timescale 1ns/1ns

interface stream_if
  import bist_fifo_pkg::*;
();

  word_t data;
  logic  last;
  logic  valid;
  logic  ready;

  modport source (output data, output last, output valid, input ready);
  modport sink   (input data, input last, input valid, output ready);

endinterface

/* hw/bist_fifo_pkg.sv */
// BIST FIFO package
// Shared types for stream words, packet control, counters and BIST state
`include "bist_fifo_defs.svh"

package bist_fifo_pkg;

  // Stream payload
  typedef logic [`DATA_W-1:0] word_t;

  // Packet geometry and throughput counters
  typedef logic [7:0]  pkt_len_t;
  typedef logic [15:0] pkt_cnt_t;
  typedef logic [31:0] perf_cnt_t;

  // Checker result
  typedef logic [1:0] bist_err_t;

  localparam bist_err_t ERR_NONE = 2'b00;
  localparam bist_err_t ERR_DATA = 2'b01;
  localparam bist_err_t ERR_LAST = 2'b10;

  // BIST sequencing
  typedef enum logic [1:0] {IDLE, RUN, DRAIN, DONE} bist_state_t;

endpackage

/* hw/bist_fifo_defs.svh */
// BIST FIFO parameters
// Stream width, bank geometry and the Wishbone register map
`ifndef BIST_FIFO_DEFS_SVH
`define BIST_FIFO_DEFS_SVH

// Stream word width
`define DATA_W 32

// --------------------------------------------------
// Bank geometry
// Four banks of 16 words give 64 words in all
`define BANK_COUNT 4
`define BANK_DEPTH 16

// --------------------------------------------------
// Register word addresses on the 3-bit Wishbone address
`define REG_CTRL   3'd0
`define REG_PKT    3'd1
`define REG_SEED   3'd2
`define REG_STATUS 3'd3
`define REG_XFER   3'd4
`define REG_CYC    3'd5

`endif
